/* all.f */
+incdir+src
src/cu_pkg.sv
src/instr_decoder.sv
src/cycle_sequencer.sv
src/control_encoder.sv
src/control_unit.sv
testbench/cu_assertions.sv
testbench/cu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module cu_tb -f all.f -o cu_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/cu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
fi
exit 1

/* src/control_encoder.sv */
module control_encoder
    import cu_pkg::*;
(
    input  state_t     state,
    input  decoded_t   dec,
    input  logic       zero,
    output ctrl_word_t ctrl
);

    // High only in the branch compare state
    logic br_cmp;
    // Branch condition, zero inverted for bne
    logic br_taken;

    assign br_taken = zero ^ dec.neg_branch;

    always_comb
    begin
        // Every field idles at zero, IDLE and DONE keep it that way
        ctrl   = '0;
        br_cmp = 1'b0;

        case (state)
            ST_FETCH:
            begin
                // Load IR from ROM and compute PC plus four
                ctrl.ir_write    = 1'b1;
                ctrl.pc_write    = 1'b1;
                ctrl.alu_src_b   = SRCB_FOUR;
                ctrl.alu_control = ALU_ADD;
            end
            ST_DECODE:
            begin
                // Latch register file outputs into A and B
                ctrl.rd_ff_en  = 1'b1;
                ctrl.alu_src_a = 1'b1;
            end
            ST_EXECUTE:
            begin
                // Operation and B operand as decoded
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_src_b     = dec.src_b;
                ctrl.alu_control   = dec.alu_op;
                ctrl.alu_result_en = 1'b1;
            end
            ST_ALU_WB:
            begin
                // ALU result to rd for R-type, rt for immediates
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = dec.rd_dest;
                ctrl.mem_to_reg = WB_ALU;
            end
            ST_ADDR:
            begin
                // Effective address is base plus immediate
                ctrl.rd_ff_en      = 1'b1;
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_src_b     = SRCB_IMM;
                ctrl.alu_control   = ALU_ADD;
                ctrl.alu_result_en = 1'b1;
            end
            ST_LOAD:
            begin
                // Read RAM at ALUOut into the data register
                ctrl.iord       = 1'b1;
                ctrl.mem_select = 1'b1;
                ctrl.data_write = 1'b1;
            end
            ST_MEM_WB:
            begin
                // Loaded data goes to rt
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = WB_MEM;
                ctrl.reg_dst    = 1'b0;
            end
            ST_STORE:
            begin
                // Write B into RAM at ALUOut
                ctrl.iord       = 1'b1;
                ctrl.mem_select = 1'b1;
                ctrl.mem_write  = 1'b1;
            end
            ST_BR_ADDR:
            begin
                // Branch target from PC plus shifted offset
                ctrl.alu_src_b     = SRCB_IMM_SHIFT;
                ctrl.alu_control   = ALU_ADD;
                ctrl.alu_result_en = 1'b1;
            end
            ST_BR_CMP:
            begin
                // Subtract to set zero, PC source is ALUOut
                ctrl.rd_ff_en    = 1'b1;
                ctrl.alu_src_a   = 1'b1;
                ctrl.alu_control = ALU_SUB;
                ctrl.pc_src      = 1'b1;
                br_cmp           = 1'b1;
            end
            ST_JUMP:
            begin
                // Unconditional PC update
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = 1'b1;
            end
            default:
            begin
                ctrl = '0;
            end
        endcase

        // PC register enable, either a plain write or a taken branch
        ctrl.pc_en = ctrl.pc_write | (br_cmp & br_taken);
    end

endmodule

/* src/control_unit.sv */
module control_unit
    import cu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  opcode_t    opcode,
    input  funct_t     funct,
    input  logic       zero,
    input  logic       req,
    output ctrl_word_t ctrl,
    output logic       ack,
    output logic       illegal
);

    decoded_t dec;
    state_t   state;

    // Opcode and funct to class and ALU fields
    instr_decoder u_decoder (
        .opcode (opcode),
        .funct  (funct),
        .dec    (dec)
    );

    // State walk and req/ack handshake
    cycle_sequencer u_sequencer (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .cls     (dec.cls),
        .state   (state),
        .ack     (ack),
        .illegal (illegal)
    );

    // Control word for the current state
    control_encoder u_encoder (
        .state (state),
        .dec   (dec),
        .zero  (zero),
        .ctrl  (ctrl)
    );

endmodule

/* src/cu_config.svh */
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// Instruction fields held by the datapath
// Opcode is bits 31:26 of the instruction word
`define CU_OPCODE_W 6

// Funct is bits 5:0, only meaningful for R-type
`define CU_FUNCT_W 6

// ALU operation select going out to the datapath ALU
// Four bits leave room for more operations later
`define CU_ALU_CTRL_W 4

// Sequencer state register
// Thirteen states used, so four bits cover them all
`define CU_STATE_W 4

// Width of the ALU B-operand mux select
// Register, constant four, immediate, shifted immediate
`define CU_SRC_B_W 2

`endif

/* src/cu_pkg.sv */
`include "cu_config.svh"

package cu_pkg;

    // Opcodes supported by the control unit
    typedef enum logic [`CU_OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0A,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    // R-type funct codes
    typedef enum logic [`CU_FUNCT_W-1:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_t;

    // ALU operations, encoding matches the datapath ALU
    typedef enum logic [`CU_ALU_CTRL_W-1:0] {
        ALU_AND = 4'd0,
        ALU_SUB = 4'd1,
        ALU_ADD = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_LUI = 4'd5
    } alu_op_t;

    // Instruction classes, each one has its own state path
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_ILLEGAL
    } instr_class_t;

    // ALU B-operand mux select
    typedef enum logic [`CU_SRC_B_W-1:0] {
        SRCB_REG       = 2'd0,
        SRCB_FOUR      = 2'd1,
        SRCB_IMM       = 2'd2,
        SRCB_IMM_SHIFT = 2'd3
    } src_b_t;

    // Register file write-back source
    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_src_t;

    // Sequencer states
    typedef enum logic [`CU_STATE_W-1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_ALU_WB,
        ST_ADDR,
        ST_LOAD,
        ST_MEM_WB,
        ST_STORE,
        ST_BR_ADDR,
        ST_BR_CMP,
        ST_JUMP,
        ST_DONE
    } state_t;

    // Decoder output shared by sequencer and encoder
    typedef struct packed {
        instr_class_t cls;
        alu_op_t      alu_op;
        src_b_t       src_b;
        // 1 selects rd, 0 selects rt
        logic         rd_dest;
        // Set for bne so the zero test is inverted
        logic         neg_branch;
    } decoded_t;

    // Control word driven to the datapath
    typedef struct packed {
        logic    iord;
        logic    mem_write;
        logic    mem_select;
        logic    ir_write;
        logic    data_write;
        wb_src_t mem_to_reg;
        logic    reg_dst;
        logic    reg_write;
        logic    rd_ff_en;
        logic    alu_src_a;
        src_b_t  alu_src_b;
        alu_op_t alu_control;
        logic    alu_result_en;
        logic    pc_src;
        logic    pc_write;
        logic    pc_en;
    } ctrl_word_t;

endpackage

/* src/cycle_sequencer.sv */
module cycle_sequencer
    import cu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         req,
    input  instr_class_t cls,
    output state_t       state,
    output logic         ack,
    output logic         illegal
);

    state_t state_next;

    // Next state, one step per clock
    // Only IDLE and DONE wait on the handshake
    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                // New instruction when the datapath raises req
                if (req)
                begin
                    state_next = ST_FETCH;
                end
            end
            ST_FETCH:   state_next = ST_DECODE;
            ST_DECODE:
            begin
                // The only branch point in the sequence
                case (cls)
                    CLS_ALU:     state_next = ST_EXECUTE;
                    CLS_LOAD:    state_next = ST_ADDR;
                    CLS_STORE:   state_next = ST_ADDR;
                    CLS_BRANCH:  state_next = ST_BR_ADDR;
                    CLS_JUMP:    state_next = ST_JUMP;
                    default:     state_next = ST_DONE;
                endcase
            end
            // ALU path
            ST_EXECUTE: state_next = ST_ALU_WB;
            ST_ALU_WB:  state_next = ST_DONE;
            // Address step is shared by lw and sw
            ST_ADDR:
            begin
                if (cls == CLS_LOAD)
                begin
                    state_next = ST_LOAD;
                end
                else
                begin
                    state_next = ST_STORE;
                end
            end
            ST_LOAD:    state_next = ST_MEM_WB;
            ST_MEM_WB:  state_next = ST_DONE;
            ST_STORE:   state_next = ST_DONE;
            // Branch target first, then the compare
            ST_BR_ADDR: state_next = ST_BR_CMP;
            ST_BR_CMP:  state_next = ST_DONE;
            ST_JUMP:    state_next = ST_DONE;
            ST_DONE:
            begin
                // Hold ack until the datapath drops req
                if (!req)
                begin
                    state_next = ST_IDLE;
                end
            end
            default:    state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // ack goes high on the edge that enters DONE
    // and low on the edge that leaves it
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= (state_next == ST_DONE);
        end
    end

    // Captured when leaving DECODE, kept through DONE
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            illegal <= 1'b0;
        end
        else if (state == ST_IDLE)
        begin
            illegal <= 1'b0;
        end
        else if (state == ST_DECODE)
        begin
            illegal <= (cls == CLS_ILLEGAL);
        end
    end

endmodule

/* src/instr_decoder.sv */
module instr_decoder
    import cu_pkg::*;
(
    input  opcode_t  opcode,
    input  funct_t   funct,
    output decoded_t dec
);

    always_comb
    begin
        // Anything not matched below stays illegal
        dec.cls        = CLS_ILLEGAL;
        dec.alu_op     = ALU_ADD;
        dec.src_b      = SRCB_IMM;
        dec.rd_dest    = 1'b0;
        dec.neg_branch = 1'b0;

        case (opcode)
            OP_RTYPE:
            begin
                // Register operands, result goes to rd
                dec.src_b   = SRCB_REG;
                dec.rd_dest = 1'b1;
                // ALU operation comes from funct
                dec.cls     = CLS_ALU;
                case (funct)
                    FN_ADD: dec.alu_op = ALU_ADD;
                    FN_SUB: dec.alu_op = ALU_SUB;
                    FN_AND: dec.alu_op = ALU_AND;
                    FN_OR:  dec.alu_op = ALU_OR;
                    FN_SLT: dec.alu_op = ALU_SLT;
                    default:
                    begin
                        // Unknown funct is an undefined instruction
                        dec.cls = CLS_ILLEGAL;
                    end
                endcase
            end
            // Immediate ALU operations, result goes to rt
            OP_ADDI:
            begin
                dec.cls    = CLS_ALU;
                dec.alu_op = ALU_ADD;
            end
            OP_ANDI:
            begin
                dec.cls    = CLS_ALU;
                dec.alu_op = ALU_AND;
            end
            OP_ORI:
            begin
                dec.cls    = CLS_ALU;
                dec.alu_op = ALU_OR;
            end
            OP_SLTI:
            begin
                dec.cls    = CLS_ALU;
                dec.alu_op = ALU_SLT;
            end
            OP_LUI:
            begin
                dec.cls    = CLS_ALU;
                dec.alu_op = ALU_LUI;
            end
            // Memory access, base plus offset is an add
            OP_LW:  dec.cls = CLS_LOAD;
            OP_SW:  dec.cls = CLS_STORE;
            // Branches compare by subtraction
            OP_BEQ:
            begin
                dec.cls    = CLS_BRANCH;
                dec.alu_op = ALU_SUB;
            end
            OP_BNE:
            begin
                dec.cls        = CLS_BRANCH;
                dec.alu_op     = ALU_SUB;
                dec.neg_branch = 1'b1;
            end
            OP_J:   dec.cls = CLS_JUMP;
            default:
            begin
                dec.cls = CLS_ILLEGAL;
            end
        endcase
    end

endmodule

/* testbench/cu_assertions.sv */
module cu_assertions
    import cu_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       req,
    input logic       ack,
    input ctrl_word_t ctrl
);

    // ack only rises in answer to a pending req
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!reset) $rose(ack) |-> req
    ) else $error("ack rose while req was low");

    // DONE leaves on the first edge that sees req low
    ack_follows_req: assert property (
        @(posedge clk) disable iff (!reset) $fell(req) |=> !ack
    ) else $error("ack still high one cycle after req fell");

    // No state writes memory and the register file together
    single_writer: assert property (
        @(posedge clk) disable iff (!reset) !(ctrl.mem_write && ctrl.reg_write)
    ) else $error("mem_write and reg_write high together");

    // DONE drives an idle word
    idle_while_ack: assert property (
        @(posedge clk) disable iff (!reset) ack |-> (ctrl == '0)
    ) else $error("ctrl not zero while ack is high");

endmodule

bind control_unit cu_assertions u_assertions (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .ack   (ack),
    .ctrl  (ctrl)
);

/* testbench/cu_tb.sv */
module cu_tb
    import cu_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        zero;
    logic        req;
    opcode_t     opcode;
    funct_t      funct;
    ctrl_word_t  ctrl;
    logic        ack;
    logic        illegal;

    // Words seen from req up to ack, index 0 is the IDLE cycle
    ctrl_word_t  rec[$];
    int          cycles;
    int          fall_cycles;
    logic        ill_at_ack;
    int          errors;
    int          test_errors;
    int          tests;
    int          failed_tests;
    logic [31:0] lcg_state;

    control_unit dut (
        .clk     (clk),
        .reset   (reset),
        .opcode  (opcode),
        .funct   (funct),
        .zero    (zero),
        .req     (req),
        .ctrl    (ctrl),
        .ack     (ack),
        .illegal (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_ctrl(input ctrl_word_t got, input ctrl_word_t exp, input string what);
        if (got !== exp)
        begin
            $display("Fail at %0t: %s, ctrl %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_state_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            $display("Fail at %0t: %s, got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("Fail at %0t: %s, got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout at %0t: %s", $time, why);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors)
            $display("%s: ok", name);
        else
        begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // Four-phase exchange, req held for hold cycles after ack
    task automatic issue_instr(input opcode_t op, input funct_t fn, input logic z, input int hold);
        rec.delete();
        cycles = 0;
        fall_cycles = 0;
        @(posedge clk);
        opcode <= op;
        funct  <= fn;
        zero   <= z;
        req    <= 1'b1;
        @(negedge clk);
        while (!ack && cycles < 16)
        begin
            rec.push_back(ctrl);
            cycles++;
            @(negedge clk);
        end
        if (!ack)
            abort_run("ack never rose");
        ill_at_ack = illegal;
        // Back-pressure, DONE must hold
        for (int i = 0; i < hold; i++)
        begin
            @(posedge clk);
            @(negedge clk);
            check_flag(ack, 1'b1, "ack during back-pressure");
            check_ctrl(ctrl, '0, "ctrl during back-pressure");
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack && fall_cycles < 16)
        begin
            fall_cycles++;
            @(negedge clk);
        end
        if (ack)
            abort_run("ack never fell after req dropped");
    endtask

    // ALU operate step, also the address step with rd_ff_en added
    function automatic ctrl_word_t execute_word(input alu_op_t op, input src_b_t sb);
        ctrl_word_t w;
        w = '0;
        w.alu_src_a     = 1'b1;
        w.alu_src_b     = sb;
        w.alu_control   = op;
        w.alu_result_en = 1'b1;
        return w;
    endfunction

    // Register or memory write cycles among the recorded words
    function automatic int count_writes(input logic mem);
        int n;
        n = 0;
        foreach (rec[i])
        begin
            if (mem ? rec[i].mem_write : rec[i].reg_write)
                n++;
        end
        return n;
    endfunction

    // Shared IDLE, FETCH, DECODE prefix of every path
    task automatic verify_fetch_decode();
        ctrl_word_t w;
        w = '0;
        check_ctrl(rec[0], w, "IDLE word");
        w.ir_write    = 1'b1;
        w.pc_write    = 1'b1;
        w.pc_en       = 1'b1;
        w.alu_src_b   = SRCB_FOUR;
        w.alu_control = ALU_ADD;
        check_ctrl(rec[1], w, "FETCH word");
        w = '0;
        w.rd_ff_en  = 1'b1;
        w.alu_src_a = 1'b1;
        check_ctrl(rec[2], w, "DECODE word");
    endtask

    task automatic test_reset();
        for (int i = 0; i < 3; i++)
        begin
            @(negedge clk);
            check_flag(ack, 1'b0, "ack after reset");
            check_flag(illegal, 1'b0, "illegal after reset");
            check_ctrl(ctrl, '0, "ctrl with req low");
        end
        end_test("reset");
    endtask

    task automatic test_alu(input opcode_t op, input funct_t fn, input alu_op_t alu,
                            input src_b_t sb, input logic rd, input string name);
        logic [31:0] r;
        // Zero flag is a don't care here
        r = lcg_next();
        issue_instr(op, fn, r[20], 0);
        check_state_count(cycles, 5, "ALU cycles to ack");
        verify_fetch_decode();
        check_ctrl(rec[3], execute_word(alu, sb), "EXECUTE word");
        check_state_count(count_writes(1'b0), 1, "reg_write cycles");
        check_flag(rec[4].reg_write, 1'b1, "reg_write in ALU_WB");
        check_flag(rec[4].reg_dst, rd, "reg_dst in ALU_WB");
        end_test(name);
    endtask

    task automatic test_load_store();
        ctrl_word_t w;
        w = execute_word(ALU_ADD, SRCB_IMM);
        w.rd_ff_en = 1'b1;
        issue_instr(OP_LW, FN_ADD, 1'b0, 0);
        check_state_count(cycles, 6, "lw cycles to ack");
        verify_fetch_decode();
        check_ctrl(rec[3], w, "lw ADDR word");
        check_flag(rec[4].data_write, 1'b1, "data_write in LOAD");
        check_flag(rec[5].reg_write, 1'b1, "reg_write in MEM_WB");
        check_flag(rec[5].mem_to_reg == WB_MEM, 1'b1, "mem_to_reg in MEM_WB");
        check_state_count(count_writes(1'b0), 1, "lw reg_write cycles");
        end_test("lw");
        issue_instr(OP_SW, FN_ADD, 1'b0, 0);
        check_state_count(cycles, 5, "sw cycles to ack");
        check_ctrl(rec[3], w, "sw ADDR word");
        check_state_count(count_writes(1'b1), 1, "sw mem_write cycles");
        check_state_count(count_writes(1'b0), 0, "sw reg_write cycles");
        end_test("sw");
    endtask

    task automatic test_branch(input opcode_t op, input logic z);
        ctrl_word_t w;
        logic       taken;
        // beq takes on zero, bne on not zero
        taken = (op == OP_BEQ) ? z : ~z;
        w = '0;
        w.rd_ff_en    = 1'b1;
        w.alu_src_a   = 1'b1;
        w.alu_control = ALU_SUB;
        w.pc_src      = 1'b1;
        w.pc_en       = taken;
        issue_instr(op, FN_ADD, z, 0);
        check_state_count(cycles, 5, "branch cycles to ack");
        check_ctrl(rec[4], w, "BR_CMP word");
        end_test($sformatf("%s zero=%0b", op.name(), z));
    endtask

    task automatic test_jump();
        issue_instr(OP_J, FN_ADD, 1'b0, 0);
        check_state_count(cycles, 4, "j cycles to ack");
        check_flag(rec[3].pc_write, 1'b1, "pc_write in JUMP");
        check_flag(rec[3].pc_en, 1'b1, "pc_en in JUMP");
        end_test("j");
    endtask

    task automatic test_illegal(input opcode_t op, input funct_t fn, input string name);
        issue_instr(op, fn, 1'b0, 0);
        check_state_count(cycles, 3, "illegal cycles to ack");
        check_flag(ill_at_ack, 1'b1, "illegal at ack");
        check_state_count(count_writes(1'b0) + count_writes(1'b1), 0, "writes when illegal");
        // A valid instruction clears the flag
        issue_instr(OP_ADDI, FN_ADD, 1'b0, 0);
        check_flag(ill_at_ack, 1'b0, "illegal after valid instruction");
        end_test(name);
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        for (int i = 0; i < 4; i++)
        begin
            r = lcg_next();
            issue_instr(OP_ORI, FN_ADD, 1'b0, int'(r[26:24]));
            check_state_count(fall_cycles, 1, "cycles from req low to ack low");
        end
        end_test("back-pressure");
    endtask

    initial
    begin
        lcg_state = 32'hcb62_50be;
        errors = 0;
        test_errors = 0;
        tests = 0;
        failed_tests = 0;
        reset  <= 1'b0;
        req    <= 1'b0;
        zero   <= 1'b0;
        opcode <= OP_RTYPE;
        funct  <= FN_ADD;
        repeat (5) @(posedge clk);
        reset <= 1'b1;
        test_reset();
        test_alu(OP_RTYPE, FN_ADD, ALU_ADD, SRCB_REG, 1'b1, "add");
        test_alu(OP_RTYPE, FN_SUB, ALU_SUB, SRCB_REG, 1'b1, "sub");
        test_alu(OP_RTYPE, FN_AND, ALU_AND, SRCB_REG, 1'b1, "and");
        test_alu(OP_RTYPE, FN_OR, ALU_OR, SRCB_REG, 1'b1, "or");
        test_alu(OP_RTYPE, FN_SLT, ALU_SLT, SRCB_REG, 1'b1, "slt");
        test_alu(OP_ADDI, FN_ADD, ALU_ADD, SRCB_IMM, 1'b0, "addi");
        test_alu(OP_ANDI, FN_ADD, ALU_AND, SRCB_IMM, 1'b0, "andi");
        test_alu(OP_ORI, FN_ADD, ALU_OR, SRCB_IMM, 1'b0, "ori");
        test_alu(OP_SLTI, FN_ADD, ALU_SLT, SRCB_IMM, 1'b0, "slti");
        test_alu(OP_LUI, FN_ADD, ALU_LUI, SRCB_IMM, 1'b0, "lui");
        test_load_store();
        test_branch(OP_BEQ, 1'b0);
        test_branch(OP_BEQ, 1'b1);
        test_branch(OP_BNE, 1'b0);
        test_branch(OP_BNE, 1'b1);
        test_jump();
        test_illegal(opcode_t'(6'h3F), FN_ADD, "undefined opcode");
        test_illegal(OP_RTYPE, funct_t'(6'h01), "undefined funct");
        test_backpressure();
        $display("Tests: %0d run, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
